// ==== filelist.f ====
+incdir+.
bst_pkg.sv
bst_slot_alloc.sv
bst_node_ram.sv
bst_walker.sv
bst_engine_top.sv
tb_bst_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the tree engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module tb_bst_engine -Mdir obj_dir -o sim_bst
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

./obj_dir/sim_bst > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
exit 0

// ==== tb_bst_tasks.svh ====
/*
 * Command tasks, random source and model lookup for the tree engine testbench.
 * Included inside the testbench module after its signal declarations.
 */

// LCG step, full 32-bit state
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Earliest stored pair wins, a miss gives data 0 and status 1
function automatic bst_pkg::bst_cpl_t model_expect(input logic [7:0] tok);
    bst_pkg::bst_cpl_t exp;
    exp.data   = '0;
    exp.status = 1'b1;
    for (int i = model_count - 1; i >= 0; i--) begin
        if (model_token[i] == tok) begin
            exp.data   = model_payload[i];
            exp.status = 1'b0;
        end
    end
    return exp;
endfunction

// Random token not yet in the model
function automatic logic [7:0] fresh_token();
    logic [31:0]       r;
    bst_pkg::bst_cpl_t e;
    r = lcg_next();
    e = model_expect(r[23:16]);
    while (e.status == 1'b0) begin
        r = lcg_next();
        e = model_expect(r[23:16]);
    end
    return r[23:16];
endfunction

// Next falling edge with the walker idle
task automatic wait_idle();
    @(negedge aclk);
    while (!req_ready) @(negedge aclk);
endtask

task automatic send_insert(input logic [7:0] tok, input logic [31:0] pay);
    wait_idle();
    // Beyond capacity the DUT drops it
    if (model_count < bst_pkg::NODE_COUNT) begin
        model_token[model_count]   = tok;
        model_payload[model_count] = pay;
        model_count++;
    end
    req       = '{cmd: bst_pkg::CMD_INSERT, token: tok, data: pay};
    req_valid = 1'b1;
    @(negedge aclk);
    req_valid = 1'b0;
endtask

// Hold cpl_ready low for hold cycles once cpl_valid is up
task automatic send_search(input logic [7:0] tok, input int hold);
    wait_idle();
    exp_cpl     = model_expect(tok);
    exp_pending = 1'b1;
    cpl_ready   = (hold == 0);
    req         = '{cmd: bst_pkg::CMD_SEARCH, token: tok, data: '0};
    req_valid   = 1'b1;
    @(negedge aclk);
    req_valid = 1'b0;
    while (!cpl_valid) @(negedge aclk);
    repeat (hold) @(negedge aclk);
    cpl_ready = 1'b1;
    @(negedge aclk);
    exp_pending = 1'b0;
endtask

// ==== tb_bst_engine.sv ====
/*
 * Testbench for the tree engine. Drives inserts and searches, checks every
 * completion with concurrent assertions against a list model of the tree.
 */

`timescale 1ns/1ps

module tb_bst_engine;

    // About 45 commands of at most 60 cycles each, with a wide margin
    localparam int TIMEOUT_CYCLES = 10000;

    logic              aclk;
    logic              aresetn;
    logic              req_valid;
    logic              req_ready;
    bst_pkg::bst_req_t req;
    logic              cpl_valid;
    logic              cpl_ready;
    bst_pkg::bst_cpl_t cpl;

    // Expected completion as posted by the search task
    bst_pkg::bst_cpl_t exp_cpl;
    logic              exp_pending;
    int                cycle_count = 0;

    // Model of stored pairs in insertion order
    logic [7:0]  model_token   [bst_pkg::NODE_COUNT];
    logic [31:0] model_payload [bst_pkg::NODE_COUNT];
    int          model_count;
    logic [31:0] lcg_state = 32'd8533;
    logic [7:0]  drop_tok;

    bst_engine_top u_bst_engine_top (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .cpl_valid (cpl_valid),
        .cpl_ready (cpl_ready),
        .cpl       (cpl)
    );

    // Print the error and the fail line, then stop
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    `include "tb_bst_tasks.svh"

    // --------------------------------------------------
    // Clock and watchdog
    // --------------------------------------------------

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the DUT stopped answering before the tests ended");
        end
    end

    // --------------------------------------------------
    // Completion checks
    // --------------------------------------------------

    // Value of every completion transfer
    a_cpl_value: assert property (@(posedge aclk) disable iff (!aresetn)
        cpl_valid && cpl_ready |-> cpl == exp_cpl)
        else fail_run($sformatf("mismatch at %0t: got data %h status %b, expected %h %b",
            $time, cpl.data, cpl.status, exp_cpl.data, exp_cpl.status));

    // Only a search may complete
    a_cpl_owner: assert property (@(posedge aclk) disable iff (!aresetn)
        cpl_valid |-> exp_pending)
        else fail_run($sformatf("mismatch at %0t: completion with no search pending", $time));

    // Held completion keeps its value
    a_cpl_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        cpl_valid && !cpl_ready |=> cpl_valid && $stable(cpl))
        else fail_run($sformatf("mismatch at %0t: completion changed under back-pressure",
            $time));

    // No new command while a completion waits
    a_req_block: assert property (@(posedge aclk) disable iff (!aresetn)
        cpl_valid |-> !req_ready)
        else fail_run($sformatf("mismatch at %0t: req_ready high during completion", $time));

    // Exactly one transfer per completion
    a_cpl_once: assert property (@(posedge aclk) disable iff (!aresetn)
        cpl_valid && cpl_ready |=> !cpl_valid)
        else fail_run($sformatf("mismatch at %0t: completion repeated after transfer", $time));

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        aresetn     = 1'b0;
        req_valid   = 1'b0;
        req         = '{cmd: bst_pkg::CMD_SEARCH, token: '0, data: '0};
        cpl_ready   = 1'b1;
        exp_cpl     = '{data: '0, status: 1'b1};
        exp_pending = 1'b0;
        model_count = 0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;

        // Empty tree
        send_search(fresh_token(), 0);
        // Fill to capacity with unique tokens and two duplicates
        for (int k = 0; k < 12; k++) begin
            send_insert(fresh_token(), lcg_next());
        end
        send_insert(model_token[2], lcg_next());
        send_insert(model_token[5], lcg_next());
        send_insert(fresh_token(), lcg_next());
        send_insert(fresh_token(), lcg_next());
        // Allocator is full so this insert is dropped
        drop_tok = fresh_token();
        send_insert(drop_tok, lcg_next());
        send_search(drop_tok, 0);
        // Every stored token where duplicates resolve to the earliest
        for (int k = 0; k < model_count; k++) begin
            send_search(model_token[k], 0);
        end
        repeat (6) send_search(fresh_token(), 0);
        // Back-pressure on a hit and on a miss
        send_search(model_token[0], 4);
        send_search(fresh_token(), 3);
        repeat (4) @(negedge aclk);
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== bst_engine_top.sv ====
/*
 * Top level of the tree engine: walker, node memory and slot allocator.
 * Commands in on req, search results out on cpl.
 */

`timescale 1ns/1ps

module bst_engine_top (
    input  logic              aclk,
    input  logic              aresetn,
    // Request port
    input  logic              req_valid,
    output logic              req_ready,
    input  bst_pkg::bst_req_t req,
    // Completion port
    output logic              cpl_valid,
    input  logic              cpl_ready,
    output bst_pkg::bst_cpl_t cpl
);

    // --------------------------------------------------
    // Internal links
    // --------------------------------------------------

    // Allocator side
    logic               alloc_take;
    bst_pkg::bst_addr_t alloc_addr;
    logic               alloc_full;

    // Node memory side
    logic               ram_wr;
    logic               ram_rd;
    bst_pkg::bst_addr_t ram_addr;
    bst_pkg::bst_node_t ram_wdata;
    bst_pkg::bst_node_t ram_rdata;
    logic               ram_rvalid;

    // Command capture and tree walk
    bst_walker u_bst_walker (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .cpl_valid  (cpl_valid),
        .cpl_ready  (cpl_ready),
        .cpl        (cpl),
        .alloc_take (alloc_take),
        .alloc_addr (alloc_addr),
        .alloc_full (alloc_full),
        .ram_wr     (ram_wr),
        .ram_rd     (ram_rd),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rvalid (ram_rvalid),
        .ram_rdata  (ram_rdata)
    );

    // Node storage
    bst_node_ram u_bst_node_ram (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .ram_wr     (ram_wr),
        .ram_rd     (ram_rd),
        .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid)
    );

    // Free slot counter
    bst_slot_alloc u_bst_slot_alloc (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .alloc_take (alloc_take),
        .alloc_addr (alloc_addr),
        .alloc_full (alloc_full)
    );

endmodule

// ==== bst_walker.sv ====
/*
 * Sequential tree walker. Accepts one command at a time, walks the tree
 * through the node memory and returns search results on the completion port.
 */

`timescale 1ns/1ps

module bst_walker (
    input  logic                       aclk,
    input  logic                       aresetn,
    // Request port
    input  logic                       req_valid,
    output logic                       req_ready,
    input  bst_pkg::bst_req_t          req,
    // Completion port
    output logic                       cpl_valid,
    input  logic                       cpl_ready,
    output bst_pkg::bst_cpl_t          cpl,
    // Slot allocator
    output logic                       alloc_take,
    input  bst_pkg::bst_addr_t         alloc_addr,
    input  logic                       alloc_full,
    // Node memory
    output logic                       ram_wr,
    output logic                       ram_rd,
    output bst_pkg::bst_addr_t         ram_addr,
    output bst_pkg::bst_node_t         ram_wdata,
    input  logic                       ram_rvalid,
    input  bst_pkg::bst_node_t         ram_rdata
);

    // Control state
    bst_pkg::bst_state_e state;
    // State to resume once a node access is done
    bst_pkg::bst_state_e ret_state;
    logic                tree_valid;
    // Parent already rewritten, leaf write pending
    logic                place_found;

    // Captured command and walk datapath
    logic [bst_pkg::TOKEN_WIDTH-1:0]   token_q;
    logic [bst_pkg::PAYLOAD_WIDTH-1:0] payload_q;
    bst_pkg::bst_addr_t                new_addr;
    bst_pkg::bst_addr_t                node_addr;
    bst_pkg::bst_node_t                wr_node;
    bst_pkg::bst_node_t                rd_node;
    bst_pkg::bst_cpl_t                 cpl_q;

    logic               req_fire;
    logic               insert_go;
    logic               search_go;
    logic               tok_eq;
    logic               tok_le;
    logic               child_valid;
    bst_pkg::bst_addr_t child_addr;
    bst_pkg::bst_node_t leaf_node;

    // --------------------------------------------------
    // Handshakes and node compare
    // --------------------------------------------------

    assign req_ready = (state == bst_pkg::ST_IDLE);
    assign req_fire  = req_valid && req_ready;
    // Full allocator drops the insert right at acceptance
    assign insert_go = req_fire && (req.cmd == bst_pkg::CMD_INSERT) && !alloc_full;
    assign search_go = req_fire && (req.cmd == bst_pkg::CMD_SEARCH);
    assign alloc_take = insert_go;

    assign cpl_valid = (state == bst_pkg::ST_COMPLETE);
    assign cpl       = cpl_q;

    assign ram_wr    = (state == bst_pkg::ST_WR_NODE);
    assign ram_rd    = (state == bst_pkg::ST_RD_NODE);
    assign ram_addr  = node_addr;
    assign ram_wdata = wr_node;

    // Less or equal goes left, shared by insert and search
    assign tok_eq      = (token_q == rd_node.token);
    assign tok_le      = (token_q <= rd_node.token);
    assign child_valid = tok_le ? rd_node.has_left : rd_node.has_right;
    assign child_addr  = tok_le ? rd_node.left_addr : rd_node.right_addr;

    // New leaf, no children yet
    assign leaf_node = '{
        payload:    payload_q,
        left_addr:  '0,
        right_addr: '0,
        token:      token_q,
        has_left:   1'b0,
        has_right:  1'b0
    };

    // --------------------------------------------------
    // Control FSM
    // --------------------------------------------------

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= bst_pkg::ST_IDLE;
            ret_state   <= bst_pkg::ST_IDLE;
            tree_valid  <= 1'b0;
            place_found <= 1'b0;
        end else begin
            case (state)
                bst_pkg::ST_IDLE: begin
                    if (insert_go) begin
                        state <= bst_pkg::ST_INSERT;
                    end
                    if (search_go) begin
                        // Empty tree answers at once
                        if (!tree_valid) begin
                            state <= bst_pkg::ST_COMPLETE;
                        end else begin
                            state     <= bst_pkg::ST_RD_NODE;
                            ret_state <= bst_pkg::ST_SEARCH;
                        end
                    end
                end
                bst_pkg::ST_INSERT: begin
                    // Leaf write: first node of the tree or after parent update
                    if (!tree_valid || place_found) begin
                        tree_valid  <= 1'b1;
                        place_found <= 1'b0;
                        state       <= bst_pkg::ST_WR_NODE;
                        ret_state   <= bst_pkg::ST_IDLE;
                    end else begin
                        state     <= bst_pkg::ST_RD_NODE;
                        ret_state <= bst_pkg::ST_FIND_PLACE;
                    end
                end
                bst_pkg::ST_FIND_PLACE: begin
                    if (child_valid) begin
                        state <= bst_pkg::ST_RD_NODE;
                    end else begin
                        // Empty child found, rewrite parent then come back
                        place_found <= 1'b1;
                        state       <= bst_pkg::ST_WR_NODE;
                        ret_state   <= bst_pkg::ST_INSERT;
                    end
                end
                bst_pkg::ST_SEARCH: begin
                    if (tok_eq || !child_valid) begin
                        state <= bst_pkg::ST_COMPLETE;
                    end else begin
                        state <= bst_pkg::ST_RD_NODE;
                    end
                end
                bst_pkg::ST_COMPLETE: begin
                    // Hold until the consumer takes it
                    if (cpl_ready) begin
                        state <= bst_pkg::ST_IDLE;
                    end
                end
                bst_pkg::ST_WR_NODE: begin
                    state <= ret_state;
                end
                bst_pkg::ST_RD_NODE: begin
                    state <= bst_pkg::ST_WAIT_NODE;
                end
                bst_pkg::ST_WAIT_NODE: begin
                    if (ram_rvalid) begin
                        state <= ret_state;
                    end
                end
                default: begin
                    state <= bst_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // --------------------------------------------------
    // Datapath registers
    // --------------------------------------------------

    always_ff @(posedge aclk) begin
        case (state)
            bst_pkg::ST_IDLE: begin
                if (req_fire) begin
                    token_q   <= req.token;
                    payload_q <= req.data;
                    new_addr  <= alloc_addr;
                end
                // Preload a miss, kept when the tree is empty
                if (search_go) begin
                    node_addr    <= bst_pkg::ROOT_ADDR;
                    cpl_q.data   <= '0;
                    cpl_q.status <= bst_pkg::STATUS_MISS;
                end
            end
            bst_pkg::ST_INSERT: begin
                if (!tree_valid || place_found) begin
                    node_addr <= new_addr;
                    wr_node   <= leaf_node;
                end else begin
                    node_addr <= bst_pkg::ROOT_ADDR;
                end
            end
            bst_pkg::ST_FIND_PLACE: begin
                if (child_valid) begin
                    node_addr <= child_addr;
                end else begin
                    // Parent keeps its address, only the link changes
                    wr_node <= rd_node;
                    if (tok_le) begin
                        wr_node.left_addr <= new_addr;
                        wr_node.has_left  <= 1'b1;
                    end else begin
                        wr_node.right_addr <= new_addr;
                        wr_node.has_right  <= 1'b1;
                    end
                end
            end
            bst_pkg::ST_SEARCH: begin
                if (tok_eq) begin
                    cpl_q.data   <= rd_node.payload;
                    cpl_q.status <= bst_pkg::STATUS_OK;
                end else if (!child_valid) begin
                    cpl_q.data   <= '0;
                    cpl_q.status <= bst_pkg::STATUS_MISS;
                end else begin
                    node_addr <= child_addr;
                end
            end
            bst_pkg::ST_WAIT_NODE: begin
                if (ram_rvalid) begin
                    rd_node <= ram_rdata;
                end
            end
            default: begin
                // Nothing to load in the other states
            end
        endcase
    end

endmodule

// ==== bst_node_ram.sv ====
/*
 * Node storage for the tree. Writes land on the strobe edge,
 * reads return one cycle after the read strobe with ram_rvalid.
 */

`timescale 1ns/1ps

module bst_node_ram (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               ram_wr,
    input  logic               ram_rd,
    input  bst_pkg::bst_addr_t ram_addr,
    input  bst_pkg::bst_node_t ram_wdata,
    output bst_pkg::bst_node_t ram_rdata,
    output logic               ram_rvalid
);

    // Register array, one entry per node slot
    bst_pkg::bst_node_t mem [bst_pkg::NODE_COUNT];

    // Write port and registered read data
    always_ff @(posedge aclk) begin
        if (ram_wr) begin
            mem[ram_addr] <= ram_wdata;
        end
        if (ram_rd) begin
            ram_rdata <= mem[ram_addr];
        end
    end

    // Read valid follows the strobe by one cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ram_rvalid <= 1'b0;
        end else begin
            ram_rvalid <= ram_rd;
        end
    end

endmodule

// ==== bst_slot_alloc.sv ====
/*
 * Hands out node slots in increasing order, no freeing.
 * Reports full once every slot is taken.
 */

`timescale 1ns/1ps

module bst_slot_alloc (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               alloc_take,
    output bst_pkg::bst_addr_t alloc_addr,
    output logic               alloc_full
);

    // Used slots, one bit wider than an address to reach NODE_COUNT
    logic [bst_pkg::ADDR_WIDTH:0] used_cnt;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            used_cnt <= '0;
        end else if (alloc_take && !alloc_full) begin
            used_cnt <= used_cnt + 1'b1;
        end
    end

    // Next free slot is the count itself
    assign alloc_addr = used_cnt[bst_pkg::ADDR_WIDTH-1:0];
    assign alloc_full = (used_cnt == (bst_pkg::ADDR_WIDTH+1)'(bst_pkg::NODE_COUNT));

endmodule

// ==== bst_pkg.sv ====
/*
 * Shared widths, node and command types, and walker states for the
 * binary search tree engine. Referenced by scoped names only.
 */

package bst_pkg;

    // --------------------------------------------------
    // Widths and capacity
    // --------------------------------------------------

    localparam int TOKEN_WIDTH   = 8;
    localparam int PAYLOAD_WIDTH = 32;
    localparam int NODE_COUNT    = 16;
    localparam int ADDR_WIDTH    = $clog2(NODE_COUNT);

    // Node address, one entry of the node memory
    typedef logic [ADDR_WIDTH-1:0] bst_addr_t;

    // Root always lives at the first slot the allocator hands out
    localparam bst_addr_t ROOT_ADDR = '0;

    // Completion status codes
    localparam logic STATUS_OK   = 1'b0;
    localparam logic STATUS_MISS = 1'b1;

    // --------------------------------------------------
    // Node and port payloads
    // --------------------------------------------------

    // One tree node as stored in memory, 50 bits
    typedef struct packed {
        logic [PAYLOAD_WIDTH-1:0] payload;
        bst_addr_t                left_addr;
        bst_addr_t                right_addr;
        logic [TOKEN_WIDTH-1:0]   token;
        logic                     has_left;
        logic                     has_right;
    } bst_node_t;

    // Request opcodes
    typedef enum logic [7:0] {
        CMD_INSERT = 8'd1,
        CMD_SEARCH = 8'd2
    } bst_cmd_e;

    // Command word on the request port, 48 bits
    typedef struct packed {
        bst_cmd_e                 cmd;
        logic [TOKEN_WIDTH-1:0]   token;
        logic [PAYLOAD_WIDTH-1:0] data;
    } bst_req_t;

    // Completion word, status 1 means the token was not found
    typedef struct packed {
        logic [PAYLOAD_WIDTH-1:0] data;
        logic                     status;
    } bst_cpl_t;

    // Walker FSM states
    typedef enum logic [3:0] {
        ST_IDLE       = 4'd0,
        ST_INSERT     = 4'd1,
        ST_FIND_PLACE = 4'd2,
        ST_SEARCH     = 4'd3,
        ST_COMPLETE   = 4'd4,
        ST_WR_NODE    = 4'd5,
        ST_RD_NODE    = 4'd6,
        ST_WAIT_NODE  = 4'd7
    } bst_state_e;

endpackage
